// ==== hdl/read_engine_pkg.sv ====
// Read engine shared definitions
// Widths, window limits, command codes and the job controller states

package read_engine_pkg;

	// Widths with a meaning of their own
	typedef logic [31:0] addr_t;
	typedef logic [15:0] elem_count_t;
	typedef logic [11:0] byte_size_t;
	typedef logic [2:0]  cmd_code_t;
	typedef logic        cmd_kind_t;
	typedef logic [3:0]  window_count_t;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	localparam byte_size_t  ELEM_BYTES      = 12'd4;
	localparam byte_size_t  CACHELINE_BYTES = 12'd64;
	localparam elem_count_t LINE_ELEMS      = 16'd16;
	localparam addr_t       PAGE_BYTES      = 32'd4096;
	localparam elem_count_t PAGE_ELEMS      = 16'd1024;
	// A touch moves one 128 byte block per page
	localparam byte_size_t  TOUCH_BYTES     = 12'd128;

	// Commands per window
	localparam window_count_t READ_WINDOW     = 4'd8;
	localparam window_count_t PREFETCH_WINDOW = 4'd2;

	////////////////////////////////////////
	// Command codes and kinds
	////////////////////////////////////////

	localparam cmd_code_t CMD_READ_CL_S  = 3'd1;
	localparam cmd_code_t CMD_READ_CL_NA = 3'd2;
	localparam cmd_code_t CMD_READ_PNA   = 3'd3;
	localparam cmd_code_t CMD_TOUCH      = 3'd4;

	localparam cmd_kind_t KIND_PREFETCH = 1'b0;
	localparam cmd_kind_t KIND_READ     = 1'b1;

	// Job controller states
	typedef enum logic [2:0] {
		JOB_IDLE,
		JOB_PREFETCH,
		JOB_READ,
		JOB_NEXT,
		JOB_DONE
	} job_state_t;

endpackage

// ==== hdl/mem_cmd_if.sv ====
// Command link between one issuer and the job controller
// Carries window start, issued commands and routed responses

`timescale 1ns/1ps

interface mem_cmd_if;
	import read_engine_pkg::*;

	logic        start;
	addr_t       base;
	elem_count_t remaining;
	logic        cmd_valid;
	cmd_code_t   cmd_code;
	addr_t       cmd_addr;
	byte_size_t  cmd_bytes;
	elem_count_t cmd_elems;
	logic        resp_valid;
	elem_count_t resp_elems;
	logic        window_done;

	modport issuer (
		input  start, resp_valid, resp_elems,
		output base, remaining, cmd_valid, cmd_code, cmd_addr, cmd_bytes, cmd_elems,
		output window_done
	);

	modport control (
		output start, resp_valid, resp_elems,
		input  base, remaining, cmd_valid, cmd_code, cmd_addr, cmd_bytes, cmd_elems,
		input  window_done
	);

endinterface

// ==== hdl/page_prefetcher.sv ====
// Page prefetcher
// Issues one touch command per page for a prefetch window and
// reports the window done once every touch has been answered

`timescale 1ns/1ps

module page_prefetcher (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_start,
	input  read_engine_pkg::addr_t     job_base,
	input  read_engine_pkg::elem_count_t job_size,
	input  logic                       cmd_alfull,
	mem_cmd_if.issuer                  bus
);
	import read_engine_pkg::*;

	logic          busy;
	logic          more;
	logic          issue;
	window_count_t sent;
	window_count_t recv;
	window_count_t win_sent;
	elem_count_t   page_elems;

	// A new window counts from zero on its start cycle
	assign win_sent   = bus.start ? '0 : sent;
	assign more       = (bus.remaining != '0) && (win_sent < PREFETCH_WINDOW);
	assign issue      = (bus.start || busy) && more && !cmd_alfull;
	assign page_elems = (bus.remaining > PAGE_ELEMS) ? PAGE_ELEMS : bus.remaining;

	////////////////////////////////////////
	// Window control
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy            <= 1'b0;
			sent            <= '0;
			recv            <= '0;
			bus.remaining   <= '0;
			bus.cmd_valid   <= 1'b0;
			bus.window_done <= 1'b0;
		end else begin
			bus.cmd_valid   <= issue;
			bus.window_done <= 1'b0;
			if (job_start) begin
				bus.remaining <= job_size;
			end else if (issue) begin
				bus.remaining <= bus.remaining - page_elems;
			end
			if (bus.start) begin
				busy <= 1'b1;
				sent <= window_count_t'(issue);
				recv <= '0;
			end else if (busy) begin
				sent <= sent + window_count_t'(issue);
				recv <= recv + window_count_t'(bus.resp_valid);
				// Nothing left to send and all touches answered
				if (!more && recv == sent) begin
					busy            <= 1'b0;
					bus.window_done <= 1'b1;
				end
			end
		end
	end

	// Page address and command payload
	always_ff @(posedge clock) begin
		if (job_start) begin
			bus.base <= job_base;
		end else if (issue) begin
			bus.base <= bus.base + PAGE_BYTES;
		end
		if (issue) begin
			bus.cmd_code  <= CMD_TOUCH;
			bus.cmd_addr  <= bus.base;
			bus.cmd_bytes <= TOUCH_BYTES;
			bus.cmd_elems <= page_elems;
		end
	end

endmodule

// ==== hdl/line_reader.sv ====
// Cache-line reader
// Issues line read commands for one read window, picks the command
// code and byte size per line, and tracks the returning responses

`timescale 1ns/1ps

module line_reader (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       job_start,
	input  read_engine_pkg::addr_t     job_base,
	input  read_engine_pkg::elem_count_t job_size,
	input  logic                       shared_mode,
	input  logic                       cmd_alfull,
	mem_cmd_if.issuer                  bus
);
	import read_engine_pkg::*;

	logic          busy;
	logic          more;
	logic          issue;
	logic          full_line;
	window_count_t sent;
	window_count_t recv;
	window_count_t win_sent;
	elem_count_t   line_elems;
	cmd_code_t     line_code;
	byte_size_t    line_bytes;

	assign win_sent   = bus.start ? '0 : sent;
	assign more       = (bus.remaining != '0) && (win_sent < READ_WINDOW);
	assign issue      = (bus.start || busy) && more && !cmd_alfull;
	assign full_line  = bus.remaining >= LINE_ELEMS;
	assign line_elems = full_line ? LINE_ELEMS : bus.remaining;

	////////////////////////////////////////
	// Command code and size
	////////////////////////////////////////

	always_comb begin
		if (shared_mode) begin
			line_code  = CMD_READ_CL_S;
			line_bytes = CACHELINE_BYTES;
		end else if (full_line) begin
			line_code  = CMD_READ_CL_NA;
			line_bytes = CACHELINE_BYTES;
		end else begin
			// Final partial line carries only the elements still owed
			line_code  = CMD_READ_PNA;
			line_bytes = byte_size_t'(line_elems) * ELEM_BYTES;
		end
	end

	////////////////////////////////////////
	// Window control
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy            <= 1'b0;
			sent            <= '0;
			recv            <= '0;
			bus.remaining   <= '0;
			bus.cmd_valid   <= 1'b0;
			bus.window_done <= 1'b0;
		end else begin
			bus.cmd_valid   <= issue;
			bus.window_done <= 1'b0;
			if (job_start) begin
				bus.remaining <= job_size;
			end else if (issue) begin
				bus.remaining <= bus.remaining - line_elems;
			end
			if (bus.start) begin
				busy <= 1'b1;
				sent <= window_count_t'(issue);
				recv <= '0;
			end else if (busy) begin
				sent <= sent + window_count_t'(issue);
				recv <= recv + window_count_t'(bus.resp_valid);
				if (!more && recv == sent) begin
					busy            <= 1'b0;
					bus.window_done <= 1'b1;
				end
			end
		end
	end

	// Line address and command payload
	always_ff @(posedge clock) begin
		if (job_start) begin
			bus.base <= job_base;
		end else if (issue) begin
			bus.base <= bus.base + addr_t'(CACHELINE_BYTES);
		end
		if (issue) begin
			bus.cmd_code  <= line_code;
			bus.cmd_addr  <= bus.base;
			bus.cmd_bytes <= line_bytes;
			bus.cmd_elems <= line_elems;
		end
	end

endmodule

// ==== hdl/read_job_control.sv ====
// Read job controller
// Sequences prefetch and read windows, merges both command streams
// onto one port, steers responses by kind and counts done elements

`timescale 1ns/1ps

module read_job_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_start,
	input  logic                         prefetch_en,
	mem_cmd_if.control                   pf_bus,
	mem_cmd_if.control                   rd_bus,
	input  logic                         resp_valid,
	input  read_engine_pkg::cmd_kind_t   resp_kind,
	input  read_engine_pkg::elem_count_t resp_elems,
	output logic                         cmd_valid,
	output read_engine_pkg::cmd_kind_t   cmd_kind,
	output read_engine_pkg::cmd_code_t   cmd_code,
	output read_engine_pkg::addr_t       cmd_addr,
	output read_engine_pkg::byte_size_t  cmd_bytes,
	output read_engine_pkg::elem_count_t cmd_elems,
	output read_engine_pkg::elem_count_t elems_done,
	output logic                         job_done
);
	import read_engine_pkg::*;

	job_state_t state;
	job_state_t state_next;
	logic       pf_en;
	logic       win_busy;

	// Window start strobes
	assign pf_bus.start = (state == JOB_PREFETCH) && !win_busy && (pf_bus.remaining != '0);
	assign rd_bus.start = (state == JOB_READ) && !win_busy && (rd_bus.remaining != '0);

	// Responses go back to the issuer of their kind
	assign pf_bus.resp_valid = resp_valid && (resp_kind == KIND_PREFETCH);
	assign pf_bus.resp_elems = resp_elems;
	assign rd_bus.resp_valid = resp_valid && (resp_kind == KIND_READ);
	assign rd_bus.resp_elems = resp_elems;

	assign job_done = (state == JOB_DONE);

	////////////////////////////////////////
	// Job state machine
	////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			JOB_IDLE: begin
				if (job_start) begin
					state_next = prefetch_en ? JOB_PREFETCH : JOB_READ;
				end
			end
			JOB_PREFETCH: begin
				if (win_busy) begin
					if (pf_bus.window_done) begin
						state_next = JOB_READ;
					end
				end else if (pf_bus.remaining == '0) begin
					// All pages already touched
					state_next = (rd_bus.remaining == '0) ? JOB_DONE : JOB_READ;
				end
			end
			JOB_READ: begin
				if (win_busy) begin
					if (rd_bus.window_done) begin
						state_next = JOB_NEXT;
					end
				end else if (rd_bus.remaining == '0) begin
					state_next = JOB_DONE;
				end
			end
			JOB_NEXT: begin
				if (rd_bus.remaining != '0) begin
					state_next = pf_en ? JOB_PREFETCH : JOB_READ;
				end else begin
					state_next = JOB_DONE;
				end
			end
			default: begin
				state_next = JOB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= JOB_IDLE;
			pf_en      <= 1'b0;
			win_busy   <= 1'b0;
			elems_done <= '0;
			cmd_valid  <= 1'b0;
		end else begin
			state     <= state_next;
			cmd_valid <= pf_bus.cmd_valid || rd_bus.cmd_valid;
			if (state == JOB_IDLE && job_start) begin
				pf_en      <= prefetch_en;
				elems_done <= '0;
			end else if (rd_bus.resp_valid) begin
				elems_done <= elems_done + rd_bus.resp_elems;
			end
			if (pf_bus.start || rd_bus.start) begin
				win_busy <= 1'b1;
			end else if (pf_bus.window_done || rd_bus.window_done) begin
				win_busy <= 1'b0;
			end
		end
	end

	// Only one issuer sends at a time
	always_ff @(posedge clock) begin
		if (pf_bus.cmd_valid) begin
			cmd_kind  <= KIND_PREFETCH;
			cmd_code  <= pf_bus.cmd_code;
			cmd_addr  <= pf_bus.cmd_addr;
			cmd_bytes <= pf_bus.cmd_bytes;
			cmd_elems <= pf_bus.cmd_elems;
		end else if (rd_bus.cmd_valid) begin
			cmd_kind  <= KIND_READ;
			cmd_code  <= rd_bus.cmd_code;
			cmd_addr  <= rd_bus.cmd_addr;
			cmd_bytes <= rd_bus.cmd_bytes;
			cmd_elems <= rd_bus.cmd_elems;
		end
	end

endmodule

// ==== hdl/read_engine_top.sv ====
// Read engine top level
// Job controller with a page prefetcher and a line reader beside it

`timescale 1ns/1ps

module read_engine_top (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_start,
	input  read_engine_pkg::addr_t       job_base,
	input  read_engine_pkg::elem_count_t job_size,
	input  logic                         prefetch_en,
	input  logic                         shared_mode,
	input  logic                         cmd_alfull,
	input  logic                         resp_valid,
	input  read_engine_pkg::cmd_kind_t   resp_kind,
	input  read_engine_pkg::elem_count_t resp_elems,
	output logic                         cmd_valid,
	output read_engine_pkg::cmd_kind_t   cmd_kind,
	output read_engine_pkg::cmd_code_t   cmd_code,
	output read_engine_pkg::addr_t       cmd_addr,
	output read_engine_pkg::byte_size_t  cmd_bytes,
	output read_engine_pkg::elem_count_t cmd_elems,
	output read_engine_pkg::elem_count_t elems_done,
	output logic                         job_done
);

	mem_cmd_if pf_bus ();
	mem_cmd_if rd_bus ();

	read_job_control i_control (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start),
		.prefetch_en (prefetch_en),
		.pf_bus      (pf_bus.control),
		.rd_bus      (rd_bus.control),
		.resp_valid  (resp_valid),
		.resp_kind   (resp_kind),
		.resp_elems  (resp_elems),
		.cmd_valid   (cmd_valid),
		.cmd_kind    (cmd_kind),
		.cmd_code    (cmd_code),
		.cmd_addr    (cmd_addr),
		.cmd_bytes   (cmd_bytes),
		.cmd_elems   (cmd_elems),
		.elems_done  (elems_done),
		.job_done    (job_done)
	);

	page_prefetcher i_prefetcher (
		.clock      (clock),
		.rstn       (rstn),
		.job_start  (job_start),
		.job_base   (job_base),
		.job_size   (job_size),
		.cmd_alfull (cmd_alfull),
		.bus        (pf_bus.issuer)
	);

	line_reader i_reader (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start),
		.job_base    (job_base),
		.job_size    (job_size),
		.shared_mode (shared_mode),
		.cmd_alfull  (cmd_alfull),
		.bus         (rd_bus.issuer)
	);

endmodule

// ==== bench/read_engine_assertions.sv ====
// Read engine protocol assertions
// Command gating by almost full and the framing of each job

`timescale 1ns/1ps

module read_engine_assertions (
	input logic clock,
	input logic rstn,
	input logic job_start,
	input logic job_done,
	input logic cmd_valid,
	input logic cmd_alfull
);

	int   gate_fails  = 0;
	int   pulse_fails = 0;
	int   frame_fails = 0;
	int   fail_count;
	logic in_job;

	assign fail_count = gate_fails + pulse_fails + frame_fails;

	// High from an accepted start until job done
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_job <= 1'b0;
		end else if (job_done) begin
			in_job <= 1'b0;
		end else if (job_start) begin
			in_job <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Protocol properties
	////////////////////////////////////////

	// Two full cycles in a row block the command two cycles on
	no_cmd_when_full: assert property (@(posedge clock) disable iff (!rstn)
		($past(cmd_alfull, 3) && $past(cmd_alfull, 2)) |-> !cmd_valid)
	else begin
		$error("cmd_valid high two cycles after cmd_alfull held high");
		gate_fails++;
	end

	done_is_pulse: assert property (@(posedge clock) disable iff (!rstn)
		job_done |=> !job_done)
	else begin
		$error("job_done high for more than one cycle");
		pulse_fails++;
	end

	cmd_inside_job: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> in_job)
	else begin
		$error("cmd_valid outside of a running job");
		frame_fails++;
	end

endmodule

// ==== bench/read_engine_tb.sv ====
// Read engine testbench
// Random jobs checked against a window model, with a memory responder
// that answers every command after a random delay

`timescale 1ns/1ps

module read_engine_tb;
	import read_engine_pkg::*;

	localparam int JOB_COUNT      = 40;
	localparam int TIMEOUT_CYCLES = JOB_COUNT * 2000;

	logic        clock;
	logic        rstn;
	logic        job_start;
	addr_t       job_base;
	elem_count_t job_size;
	logic        prefetch_en;
	logic        shared_mode;
	logic        cmd_alfull;
	logic        resp_valid;
	cmd_kind_t   resp_kind;
	elem_count_t resp_elems;
	logic        cmd_valid;
	cmd_kind_t   cmd_kind;
	cmd_code_t   cmd_code;
	addr_t       cmd_addr;
	byte_size_t  cmd_bytes;
	elem_count_t cmd_elems;
	elem_count_t elems_done;
	logic        job_done;

	int   seed;
	int   cycle_count = 0;
	int   error_count = 0;
	int   check_count = 0;
	int   out_pf = 0;
	int   out_rd = 0;
	logic job_active;
	logic done_seen;

	// Expected commands of the running job in issue order
	cmd_kind_t   exp_kind[$];
	cmd_code_t   exp_code[$];
	addr_t       exp_addr[$];
	byte_size_t  exp_bytes[$];
	elem_count_t exp_elems[$];
	logic        exp_first[$];

	// Commands waiting for their response
	cmd_kind_t   rq_kind[$];
	elem_count_t rq_elems[$];
	int          rq_due[$];

	read_engine_top i_dut (.*);

	bind read_engine_top read_engine_assertions i_assertions (
		.clock      (clock),
		.rstn       (rstn),
		.job_start  (job_start),
		.job_done   (job_done),
		.cmd_valid  (cmd_valid),
		.cmd_alfull (cmd_alfull)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", cycle_count);
			$display("Checks %0d, errors %0d, assertion failures %0d", check_count,
				error_count, i_dut.i_assertions.fail_count);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic int pick_below(input int n);
		int unsigned r;
		r = $unsigned($random(seed));
		return int'(r % $unsigned(n));
	endfunction

	////////////////////////////////////////
	// Command model
	////////////////////////////////////////

	task automatic queue_expected(input cmd_kind_t kind, input cmd_code_t code,
			input addr_t addr, input byte_size_t bytes, input elem_count_t elems,
			input logic first);
		exp_kind.push_back(kind);
		exp_code.push_back(code);
		exp_addr.push_back(addr);
		exp_bytes.push_back(bytes);
		exp_elems.push_back(elems);
		exp_first.push_back(first);
	endtask

	// Whole job in issue order with its window boundaries
	task automatic build_expected(input addr_t base, input elem_count_t size,
			input logic shared, input logic prefetch);
		addr_t       pf_addr;
		addr_t       rd_addr;
		elem_count_t pf_rem;
		elem_count_t rd_rem;
		elem_count_t n;
		cmd_code_t   code;
		byte_size_t  bytes;
		pf_addr = base;
		rd_addr = base;
		pf_rem  = size;
		rd_rem  = size;
		while (rd_rem != 0) begin
			// Touch the pages still ahead before each read window
			if (prefetch) begin
				for (int w = 0; w < int'(PREFETCH_WINDOW) && pf_rem != 0; w++) begin
					n = (pf_rem > PAGE_ELEMS) ? PAGE_ELEMS : pf_rem;
					queue_expected(KIND_PREFETCH, CMD_TOUCH, pf_addr, 12'd128, n, w == 0);
					pf_addr = pf_addr + 32'd4096;
					pf_rem  = pf_rem - n;
				end
			end
			for (int w = 0; w < int'(READ_WINDOW) && rd_rem != 0; w++) begin
				n = (rd_rem >= LINE_ELEMS) ? LINE_ELEMS : rd_rem;
				if (shared) begin
					code  = CMD_READ_CL_S;
					bytes = 12'd64;
				end else if (n == LINE_ELEMS) begin
					code  = CMD_READ_CL_NA;
					bytes = 12'd64;
				end else begin
					code  = CMD_READ_PNA;
					bytes = byte_size_t'(n) * 12'd4;
				end
				queue_expected(KIND_READ, code, rd_addr, bytes, n, w == 0);
				rd_addr = rd_addr + 32'd64;
				rd_rem  = rd_rem - n;
			end
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		check_count++;
		assert (got == want) else begin
			error_count++;
			$display("Error %s got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	task automatic check_command();
		assert (exp_addr.size() != 0) else begin
			error_count++;
			$display("Command to 0x%0h issued when none was expected", cmd_addr);
		end
		if (exp_addr.size() != 0) begin
			// A window opens only once the previous one is fully answered
			if (exp_first[0]) begin
				assert (out_pf == 0 && out_rd == 0) else begin
					error_count++;
					$display("Window opened with %0d touch and %0d read responses pending",
						out_pf, out_rd);
				end
			end
			if (cmd_kind == KIND_READ) begin
				assert (out_rd < int'(READ_WINDOW)) else begin
					error_count++;
					$display("Too many read commands outstanding (%0d)", out_rd + 1);
				end
			end
			check_value("cmd_kind", 32'(cmd_kind), 32'(exp_kind[0]));
			check_value("cmd_code", 32'(cmd_code), 32'(exp_code[0]));
			check_value("cmd_addr", cmd_addr, exp_addr[0]);
			check_value("cmd_bytes", 32'(cmd_bytes), 32'(exp_bytes[0]));
			check_value("cmd_elems", 32'(cmd_elems), 32'(exp_elems[0]));
			void'(exp_kind.pop_front());
			void'(exp_code.pop_front());
			void'(exp_addr.pop_front());
			void'(exp_bytes.pop_front());
			void'(exp_elems.pop_front());
			void'(exp_first.pop_front());
		end
		rq_kind.push_back(cmd_kind);
		rq_elems.push_back(cmd_elems);
		rq_due.push_back(cycle_count + 1 + pick_below(6));
		if (cmd_kind == KIND_READ) begin
			out_rd++;
		end else begin
			out_pf++;
		end
	endtask

	task automatic check_job_end();
		assert (job_active && !done_seen) else begin
			error_count++;
			$display("job_done pulsed with no job running");
		end
		check_value("elems_done", 32'(elems_done), 32'(job_size));
		assert (exp_addr.size() == 0 && rq_due.size() == 0) else begin
			error_count++;
			$display("Job ended with %0d commands missing and %0d responses pending",
				exp_addr.size(), rq_due.size());
		end
		done_seen = 1'b1;
	endtask

	// The first due entry goes out so later commands may overtake earlier ones
	task automatic drive_responses();
		int idx;
		idx = -1;
		resp_valid = 1'b0;
		resp_elems = '0;
		for (int i = 0; i < rq_due.size(); i++) begin
			if (idx < 0 && rq_due[i] <= cycle_count) begin
				idx = i;
			end
		end
		if (idx >= 0) begin
			resp_valid = 1'b1;
			resp_kind  = rq_kind[idx];
			resp_elems = rq_elems[idx];
			if (rq_kind[idx] == KIND_READ) begin
				out_rd--;
			end else begin
				out_pf--;
			end
			rq_kind.delete(idx);
			rq_elems.delete(idx);
			rq_due.delete(idx);
		end
	endtask

	// One clock cycle with inputs changed shortly after the edge
	task automatic step();
		@(posedge clock);
		#2;
		if (cmd_valid) begin
			check_command();
		end
		if (job_done) begin
			check_job_end();
		end
		drive_responses();
		job_start  = 1'b0;
		cmd_alfull = (pick_below(4) == 0);
	endtask

	// All four mode pairs in turn with edge case and random sizes
	task automatic choose_job(input int j);
		prefetch_en = (j % 2) == 1;
		shared_mode = ((j / 2) % 2) == 1;
		job_base    = addr_t'($random(seed)) & 32'hffff_ffc0;
		case (j % 7)
			3: job_size = '0;
			5: job_size = elem_count_t'(16 * pick_below(19));
			6: job_size = elem_count_t'(128 * (1 + pick_below(2)));
			default: job_size = elem_count_t'(1 + pick_below(300));
		endcase
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		clock       = 1'b0;
		rstn        = 1'b0;
		job_start   = 1'b0;
		job_base    = '0;
		job_size    = '0;
		prefetch_en = 1'b0;
		shared_mode = 1'b0;
		cmd_alfull  = 1'b0;
		resp_valid  = 1'b0;
		resp_kind   = KIND_PREFETCH;
		resp_elems  = '0;
		job_active  = 1'b0;
		done_seen   = 1'b0;
		seed        = 32'h9036;
		repeat (5) @(posedge clock);
		#2;
		rstn = 1'b1;
		repeat (2) step();
		for (int j = 0; j < JOB_COUNT; j++) begin
			choose_job(j);
			build_expected(job_base, job_size, shared_mode, prefetch_en);
			job_active = 1'b1;
			done_seen  = 1'b0;
			job_start  = 1'b1;
			while (!done_seen) begin
				step();
			end
			job_active = 1'b0;
			repeat (1 + pick_below(3)) step();
		end
		$display("Checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
			i_dut.i_assertions.fail_count);
		if (error_count == 0 && i_dut.i_assertions.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== read_engine.f ====
hdl/read_engine_pkg.sv
hdl/mem_cmd_if.sv
hdl/page_prefetcher.sv
hdl/line_reader.sv
hdl/read_job_control.sv
hdl/read_engine_top.sv
bench/read_engine_assertions.sv
bench/read_engine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the read engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module read_engine_tb \
	-f read_engine.f -o read_engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/read_engine_sim +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
